// ==== logic/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data and address width
`define XLEN 32

// Instruction memory size in words
`define IMEM_DEPTH 64

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Interrupt handler entry
`define IRQ_VECTOR 32'h0000_0080

`endif

// ==== logic/core_pkg.sv ====
`include "core_cfg.svh"

package core_pkg;

    // Decoded instruction class, unknown encodings map to OP_NOP
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ALU,
        OP_ALUI,
        OP_LUI,
        OP_BEQ,
        OP_BNE,
        OP_JAL,
        OP_RTI,
        OP_RDI,
        OP_SND,
        OP_HALT
    } op_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    // Fetch to decode
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
    } fetch_pkt_t;

    // Decode to execute
    typedef struct packed {
        logic             valid;
        op_t              op;
        alu_op_t          alu_op;
        logic [4:0]       rd;
        logic [`XLEN-1:0] rs1_val;
        logic [`XLEN-1:0] rs2_val;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] pc;
    } exec_pkt_t;

    // Register write, also used as the decode bypass
    typedef struct packed {
        logic             en;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
    } wb_t;

endpackage

// ==== logic/instr_mem.sv ====
`include "core_cfg.svh"

module instr_mem #(
    parameter int AW = $clog2(`IMEM_DEPTH)
) (
    input  logic             clk,
    input  logic             we,
    input  logic [AW-1:0]    waddr,
    input  logic [`XLEN-1:0] wdata,
    input  logic [AW-1:0]    raddr,
    output logic [`XLEN-1:0] rdata
);

    logic [`XLEN-1:0] mem [`IMEM_DEPTH];

    // Program load port, used while the core is held in reset
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Combinational read so fetch sees the word in the same cycle
    assign rdata = mem[raddr];

endmodule

// ==== logic/irq_ctrl.sv ====
`include "core_cfg.svh"

module irq_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             irq_key,
    input  logic             irq_eth,
    input  logic             ex_valid,
    input  logic             rti_seen,
    input  logic [`XLEN-1:0] next_pc,
    output logic             irq_take,
    output logic [`XLEN-1:0] epc
);

    logic masked;

    // Take a request only when a real instruction sits in execute,
    // otherwise there is no return address to save
    assign irq_take = (irq_key | irq_eth) & ~masked & ex_valid;

    // Mask stays set for the whole handler
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            masked <= 1'b0;
        end else if (irq_take) begin
            masked <= 1'b1;
        end else if (rti_seen) begin
            masked <= 1'b0;
        end
    end

    // Instruction in execute completes, so resume after it
    always_ff @(posedge clk) begin
        if (irq_take) begin
            epc <= next_pc;
        end
    end

endmodule

// ==== logic/fetch.sv ====
`include "core_cfg.svh"

module fetch import core_pkg::*; #(
    parameter int AW = $clog2(`IMEM_DEPTH)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             irq_take,
    input  logic             rti_seen,
    input  logic             redirect,
    input  logic             halt_seen,
    input  logic [`XLEN-1:0] epc,
    input  logic [`XLEN-1:0] redirect_pc,
    input  logic [`XLEN-1:0] rdata,
    output logic [AW-1:0]    raddr,
    output logic             flush,
    output logic             halted,
    output fetch_pkt_t       fd
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_next;

    assign raddr = pc[AW+1:2];

    // Halt also drops the two younger instructions
    assign flush = irq_take | rti_seen | redirect | halt_seen;

    always_comb begin
        if (halted || halt_seen) begin
            pc_next = pc;
        end else if (irq_take) begin
            pc_next = `IRQ_VECTOR;
        end else if (rti_seen) begin
            pc_next = epc;
        end else if (redirect) begin
            pc_next = redirect_pc;
        end else begin
            pc_next = pc + `XLEN'd4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= `RESET_PC;
            halted <= 1'b0;
            fd     <= '0;
        end else begin
            pc       <= pc_next;
            halted   <= halted | halt_seen;
            fd.valid <= ~(flush | halted);
            fd.pc    <= pc;
            fd.instr <= rdata;
        end
    end

endmodule

// ==== logic/decode.sv ====
`include "core_cfg.svh"

module decode import core_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  fetch_pkt_t       fd,
    input  wb_t              wb,
    input  logic [`XLEN-1:0] irq_data,
    output exec_pkt_t        de
);

    logic [`XLEN-1:0] regs [32];
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_u;
    exec_pkt_t        de_next;

    assign opcode = fd.instr[6:0];
    assign funct3 = fd.instr[14:12];
    assign rs1    = fd.instr[19:15];
    assign rs2    = fd.instr[24:20];

    assign imm_i = {{20{fd.instr[31]}}, fd.instr[31:20]};
    assign imm_b = {{19{fd.instr[31]}}, fd.instr[31], fd.instr[7],
                    fd.instr[30:25], fd.instr[11:8], 1'b0};
    assign imm_j = {{11{fd.instr[31]}}, fd.instr[31], fd.instr[19:12],
                    fd.instr[20], fd.instr[30:21], 1'b0};
    assign imm_u = {fd.instr[31:12], 12'b0};

    // Result written this cycle wins over the stored value
    function automatic logic [`XLEN-1:0] read_reg(input logic [4:0] idx);
        logic [`XLEN-1:0] val;
        if (idx == 5'd0) begin
            val = '0;
        end else if (wb.en && wb.rd == idx) begin
            val = wb.data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        de_next         = '0;
        de_next.valid   = fd.valid;
        de_next.op      = OP_NOP;
        de_next.alu_op  = ALU_ADD;
        de_next.rd      = fd.instr[11:7];
        de_next.rs1_val = read_reg(rs1);
        de_next.rs2_val = read_reg(rs2);
        de_next.imm     = imm_i;
        de_next.pc      = fd.pc;
        case (opcode)
            7'b0110011: begin
                de_next.op = OP_ALU;
                case ({fd.instr[30], funct3})
                    4'b0000: de_next.alu_op = ALU_ADD;
                    4'b1000: de_next.alu_op = ALU_SUB;
                    4'b0111: de_next.alu_op = ALU_AND;
                    4'b0110: de_next.alu_op = ALU_OR;
                    4'b0100: de_next.alu_op = ALU_XOR;
                    default: de_next.op = OP_NOP;
                endcase
            end
            7'b0010011: de_next.op = (funct3 == 3'b000) ? OP_ALUI : OP_NOP;
            7'b0110111: begin
                de_next.op  = OP_LUI;
                de_next.imm = imm_u;
            end
            7'b1100011: begin
                de_next.imm = imm_b;
                if (funct3 == 3'b000) begin
                    de_next.op = OP_BEQ;
                end else if (funct3 == 3'b001) begin
                    de_next.op = OP_BNE;
                end
            end
            7'b1101111: begin
                de_next.op  = OP_JAL;
                de_next.imm = imm_j;
            end
            7'b0001000: de_next.op = OP_RTI;
            7'b0001010: begin
                // Source data rides in the rs1 slot through execute
                de_next.op      = OP_RDI;
                de_next.rs1_val = irq_data;
            end
            7'b0001011: de_next.op = OP_SND;
            default: de_next.op = (fd.instr == 32'h0000_0073) ? OP_HALT : OP_NOP;
        endcase
    end

    // x0 is never written, execute masks rd 0
    always_ff @(posedge clk) begin
        if (wb.en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de <= '0;
        end else begin
            de <= de_next;
            if (flush) begin
                de.valid <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/execute.sv ====
`include "core_cfg.svh"

module execute import core_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  exec_pkt_t        de,
    output wb_t              wb,
    output logic             redirect,
    output logic             rti_seen,
    output logic             halt_seen,
    output logic [`XLEN-1:0] redirect_pc,
    output logic [`XLEN-1:0] next_pc,
    output logic             snd,
    output logic [`XLEN-1:0] send_data
);

    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] pc_plus4;
    logic             taken;
    logic             writes_rd;

    assign alu_b    = (de.op == OP_ALUI) ? de.imm : de.rs2_val;
    assign pc_plus4 = de.pc + `XLEN'd4;

    always_comb begin
        case (de.alu_op)
            ALU_SUB: alu_res = de.rs1_val - alu_b;
            ALU_AND: alu_res = de.rs1_val & alu_b;
            ALU_OR:  alu_res = de.rs1_val | alu_b;
            ALU_XOR: alu_res = de.rs1_val ^ alu_b;
            default: alu_res = de.rs1_val + alu_b;
        endcase
    end

    // JAL always leaves the sequential path
    assign taken = (de.op == OP_JAL)
                 | ((de.op == OP_BEQ) & (de.rs1_val == de.rs2_val))
                 | ((de.op == OP_BNE) & (de.rs1_val != de.rs2_val));

    assign redirect_pc = de.pc + de.imm;
    assign next_pc     = taken ? redirect_pc : pc_plus4;
    assign redirect    = de.valid & taken;
    assign rti_seen    = de.valid & (de.op == OP_RTI);
    assign halt_seen   = de.valid & (de.op == OP_HALT);

    assign writes_rd = (de.op == OP_ALU) | (de.op == OP_ALUI) | (de.op == OP_LUI)
                     | (de.op == OP_JAL) | (de.op == OP_RDI);

    always_comb begin
        wb.en = de.valid & writes_rd & (de.rd != 5'd0);
        wb.rd = de.rd;
        case (de.op)
            OP_LUI:  wb.data = de.imm;
            OP_JAL:  wb.data = pc_plus4;
            OP_RDI:  wb.data = de.rs1_val;
            default: wb.data = alu_res;
        endcase
    end

    // Send strobe lasts one cycle after SND leaves execute
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snd <= 1'b0;
        end else begin
            snd <= de.valid & (de.op == OP_SND);
        end
    end

    always_ff @(posedge clk) begin
        if (de.valid && de.op == OP_SND) begin
            send_data <= de.rs1_val;
        end
    end

endmodule

// ==== logic/proc.sv ====
`include "core_cfg.svh"

module proc import core_pkg::*; #(
    parameter int AW = $clog2(`IMEM_DEPTH)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             prog_we,
    input  logic [AW-1:0]    prog_addr,
    input  logic [`XLEN-1:0] prog_data,
    input  logic             irq_key,
    input  logic             irq_eth,
    input  logic [`XLEN-1:0] irq_data,
    output logic             snd,
    output logic [`XLEN-1:0] send_data,
    output logic             halted
);

    logic [AW-1:0]    raddr;
    logic [`XLEN-1:0] rdata;
    logic             irq_take;
    logic [`XLEN-1:0] epc;
    logic             flush;
    logic             redirect;
    logic             rti_seen;
    logic             halt_seen;
    logic [`XLEN-1:0] redirect_pc;
    logic [`XLEN-1:0] next_pc;
    fetch_pkt_t       fd;
    exec_pkt_t        de;
    wb_t              wb;

    instr_mem #(.AW(AW)) instr_mem_inst (
        .clk   (clk),
        .we    (prog_we),
        .waddr (prog_addr),
        .wdata (prog_data),
        .raddr (raddr),
        .rdata (rdata)
    );

    irq_ctrl irq_ctrl_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .irq_key  (irq_key),
        .irq_eth  (irq_eth),
        .ex_valid (de.valid),
        .rti_seen (rti_seen),
        .next_pc  (next_pc),
        .irq_take (irq_take),
        .epc      (epc)
    );

    fetch #(.AW(AW)) fetch_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_take    (irq_take),
        .rti_seen    (rti_seen),
        .redirect    (redirect),
        .halt_seen   (halt_seen),
        .epc         (epc),
        .redirect_pc (redirect_pc),
        .rdata       (rdata),
        .raddr       (raddr),
        .flush       (flush),
        .halted      (halted),
        .fd          (fd)
    );

    decode decode_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .fd       (fd),
        .wb       (wb),
        .irq_data (irq_data),
        .de       (de)
    );

    execute execute_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .de          (de),
        .wb          (wb),
        .redirect    (redirect),
        .rti_seen    (rti_seen),
        .halt_seen   (halt_seen),
        .redirect_pc (redirect_pc),
        .next_pc     (next_pc),
        .snd         (snd),
        .send_data   (send_data)
    );

endmodule

// ==== test/proc_tb.sv ====
`include "core_cfg.svh"

module proc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int AW = $clog2(`IMEM_DEPTH);
    // Five programs with a 72 cycle load each run in about 600 cycles
    localparam int MAX_CYCLES = 2000;
    localparam int LOOP_COUNT = 8;
    localparam int LOOP_MARK  = 3;
    localparam logic [31:0] RTI_WORD  = 32'h0000_0008;
    localparam logic [31:0] HALT_WORD = 32'h0000_0073;

    logic             clk;
    logic             rst_n;
    logic             prog_we;
    logic [AW-1:0]    prog_addr;
    logic [`XLEN-1:0] prog_data;
    logic             irq_key;
    logic             irq_eth;
    logic [`XLEN-1:0] irq_data;
    logic             snd;
    logic [`XLEN-1:0] send_data;
    logic             halted;

    logic [31:0] image [`IMEM_DEPTH];
    logic [31:0] expect_q [$];
    logic [15:0] lfsr_state;
    int          pos;
    int          cycles;
    int          sent;
    int          want_sends;
    int          errors;
    int          err_at_start;
    int          tests_run;
    int          tests_passed;

    proc proc_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .irq_key   (irq_key),
        .irq_eth   (irq_eth),
        .irq_data  (irq_data),
        .snd       (snd),
        .send_data (send_data),
        .halted    (halted)
    );

    always #4 clk = ~clk;

    // Instruction encoders
    function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] add_imm(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] upper_imm(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] cond_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input int off);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jump_link(input logic [4:0] rd, input int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] read_irq(input logic [4:0] rd);
        return {20'b0, rd, 7'b0001010};
    endfunction

    function automatic logic [31:0] send_reg(input logic [4:0] rs1);
        return {12'b0, rs1, 3'b000, 5'b0, 7'b0001011};
    endfunction

    function automatic logic [31:0] sign_ext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    // Unused words hold ADDI x0 with their own address as immediate
    function automatic void new_program();
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            image[i[AW-1:0]] = add_imm(5'd0, 5'd0, 12'(i));
        end
        pos = 0;
        expect_q.delete();
    endfunction

    function automatic void emit(input logic [31:0] word);
        image[pos[AW-1:0]] = word;
        pos++;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Core is held in reset while the whole image goes in
    task automatic load_and_reset();
        rst_n = 1'b0;
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            prog_we   = 1'b1;
            prog_addr = i[AW-1:0];
            prog_data = image[i[AW-1:0]];
            step();
        end
        prog_we = 1'b0;
        repeat (8) step();
        sent         = 0;
        want_sends   = expect_q.size();
        err_at_start = errors;
        rst_n        = 1'b1;
    endtask

    task automatic end_test(input string name, input int hold);
        while (!halted) begin
            step();
        end
        assert (sent == want_sends) else begin
            $display("Mismatch at time %0t: send count got %0d expected %0d",
                     $time, sent, want_sends);
            errors++;
        end
        for (int i = 0; i < hold; i++) begin
            step();
            assert (halted) else begin
                $display("The halted output dropped at time %0t", $time);
                errors++;
            end
            assert (!snd) else begin
                $display("A send strobe fired at time %0t after the core halted", $time);
                errors++;
            end
        end
        tests_run++;
        if (errors == err_at_start) begin
            tests_passed++;
            $display("%-10s passed, %0d sends", name, sent);
        end else begin
            $display("%-10s failed, %0d errors", name, errors - err_at_start);
        end
    endtask

    task automatic alu_chain_test();
        logic [19:0] up;
        logic [11:0] i1;
        logic [11:0] i2;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r3;
        logic [31:0] r4;
        logic [31:0] r5;
        logic [31:0] r6;
        logic [31:0] r7;
        up = 20'(rand_bits(20));
        i1 = 12'(rand_bits(12));
        i2 = 12'(rand_bits(12));
        a  = {up, 12'b0} + sign_ext12(i1);
        b  = sign_ext12(i2);
        r3 = a + b;
        r4 = r3 - a;
        r5 = r4 & r3;
        r6 = r5 | a;
        r7 = r6 ^ r4;
        new_program();
        emit(upper_imm(5'd1, up));
        emit(add_imm(5'd1, 5'd1, i1));
        emit(add_imm(5'd2, 5'd0, i2));
        // Every operation reads the result of the one before it
        emit(reg_op(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        emit(reg_op(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
        emit(reg_op(7'h00, 3'b111, 5'd5, 5'd4, 5'd3));
        emit(reg_op(7'h00, 3'b110, 5'd6, 5'd5, 5'd1));
        emit(reg_op(7'h00, 3'b100, 5'd7, 5'd6, 5'd4));
        emit(send_reg(5'd7));
        for (int r = 1; r <= 6; r++) begin
            emit(send_reg(5'(r)));
        end
        emit(HALT_WORD);
        expect_q = '{r7, a, b, r3, r4, r5, r6};
        load_and_reset();
        end_test("alu_chain", 0);
    endtask

    task automatic branch_test();
        logic [11:0] r1;
        logic [11:0] r3;
        r1 = 12'(rand_bits(12));
        r3 = r1 ^ 12'h5a5;
        new_program();
        emit(add_imm(5'd1, 5'd0, r1));
        emit(add_imm(5'd2, 5'd0, r1));
        emit(add_imm(5'd3, 5'd0, r3));
        emit(cond_branch(3'b000, 5'd1, 5'd2, 12));
        emit(send_reg(5'd1));
        emit(send_reg(5'd1));
        emit(cond_branch(3'b000, 5'd1, 5'd3, 12));
        emit(send_reg(5'd2));
        emit(cond_branch(3'b001, 5'd1, 5'd3, 12));
        emit(send_reg(5'd3));
        emit(send_reg(5'd3));
        emit(cond_branch(3'b001, 5'd1, 5'd2, 12));
        emit(send_reg(5'd3));
        emit(HALT_WORD);
        expect_q = '{sign_ext12(r1), sign_ext12(r3)};
        load_and_reset();
        end_test("branches", 0);
    endtask

    task automatic jump_test();
        logic [11:0] r;
        logic [31:0] jal_pc;
        r = 12'(rand_bits(12));
        new_program();
        emit(add_imm(5'd2, 5'd0, r));
        jal_pc = 32'(pos * 4);
        emit(jump_link(5'd1, 12));
        emit(send_reg(5'd2));
        emit(send_reg(5'd2));
        emit(send_reg(5'd1));
        emit(HALT_WORD);
        expect_q = '{jal_pc + 32'd4};
        load_and_reset();
        end_test("jal", 0);
    endtask

    task automatic interrupt_test();
        int loop_pos;
        irq_data = rand_bits(32);
        new_program();
        emit(add_imm(5'd1, 5'd0, 12'd0));
        emit(add_imm(5'd2, 5'd0, 12'(LOOP_COUNT)));
        loop_pos = pos;
        emit(add_imm(5'd1, 5'd1, 12'd1));
        emit(send_reg(5'd1));
        emit(cond_branch(3'b001, 5'd1, 5'd2, (loop_pos - pos) * 4));
        emit(HALT_WORD);
        pos = `IRQ_VECTOR / 4;
        emit(read_irq(5'd5));
        emit(send_reg(5'd5));
        emit(RTI_WORD);
        for (int k = 1; k <= LOOP_COUNT; k++) begin
            expect_q.push_back(32'(k));
            if (k == LOOP_MARK) begin
                expect_q.push_back(irq_data);
            end
        end
        load_and_reset();
        while (!(snd && send_data == 32'(LOOP_MARK))) begin
            step();
        end
        irq_key = 1'b1;
        repeat (3) step();
        // Second source arrives while the handler still holds the mask
        irq_key = 1'b0;
        irq_eth = 1'b1;
        while (!snd) begin
            step();
        end
        irq_eth = 1'b0;
        end_test("interrupt", 0);
    endtask

    task automatic halt_test();
        logic [11:0] r;
        r = 12'(rand_bits(12));
        new_program();
        emit(add_imm(5'd1, 5'd0, r));
        emit(send_reg(5'd1));
        emit(HALT_WORD);
        emit(send_reg(5'd1));
        emit(send_reg(5'd1));
        expect_q = '{sign_ext12(r)};
        load_and_reset();
        end_test("halt", 50);
    endtask

    // Every send is checked against the next expected value
    always @(negedge clk) begin
        if (rst_n && snd) begin
            sent++;
            assert (expect_q.size() > 0) else begin
                $display("Unexpected send of %h at time %0t with nothing left to send",
                         send_data, $time);
                errors++;
            end
            if (expect_q.size() > 0) begin
                assert (send_data == expect_q[0]) else begin
                    $display("Mismatch at time %0t: send_data got %h expected %h",
                             $time, send_data, expect_q[0]);
                    errors++;
                end
                void'(expect_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the core never finished its programs", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        irq_key      = 1'b0;
        irq_eth      = 1'b0;
        irq_data     = '0;
        lfsr_state   = 16'd26;
        cycles       = 0;
        sent         = 0;
        want_sends   = 0;
        errors       = 0;
        err_at_start = 0;
        tests_run    = 0;
        tests_passed = 0;
        alu_chain_test();
        branch_test();
        jump_test();
        interrupt_test();
        halt_test();
        $display("%0d of %0d tests passed, %0d errors", tests_passed, tests_run, errors);
        if (errors == 0 && tests_passed == tests_run) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== mini_core.f ====
+incdir+logic
logic/core_pkg.sv
logic/instr_mem.sv
logic/irq_ctrl.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/proc.sv
test/proc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps --top-module proc_tb \
    -f mini_core.f -Mdir obj_dir -o proc_tb_sim

output=$(./obj_dir/proc_tb_sim)
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
